// File: mem_wb_top.f
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
stage_if.sv
stage_reg.sv
data_ram.sv
mem_stage.sv
wb_stage.sv
regfile.sv
mem_wb_top.sv
tb_clk_gen.sv
mem_wb_tb.sv

// File: Bender.yml
package:
  name: mem_wb_top

sources:
  - cpu_isa_pkg.sv
  - cpu_pipe_pkg.sv
  - stage_if.sv
  - stage_reg.sv
  - data_ram.sv
  - mem_stage.sv
  - wb_stage.sv
  - regfile.sv
  - mem_wb_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - mem_wb_tb.sv

// File: mem_wb_tb.sv
//********************
// Testbench for mem_wb_top: stimulus,
// byte-level RAM and register model,
// commit assertions, watchdog
//********************
`timescale 1ns/1ps

module mem_wb_tb;

    import cpu_isa_pkg::*;

    localparam int          RAM_WORDS = 64;
    localparam int          RAM_BYTES = RAM_WORDS * 4;
    localparam logic [31:0] SEED      = 32'h7cd4_8946;

    // One accepted instruction as the model sees it
    typedef struct packed {
        logic [31:0] pc;
        mem_op_e     op;
        logic [31:0] alu;
        logic [31:0] sdata;
        logic [4:0]  rd;
        logic        rf_we;
        logic [2:0]  test_id;
        logic [31:0] accept_edge;                      // Edge number of the transfer in
    } issued_t;

    logic        clk;
    logic        reset_i;
    logic        in_valid_i;
    logic        in_allowin_o;
    logic [31:0] in_pc_i;
    logic [31:0] in_inst_i;
    mem_op_e     in_op_i;
    logic [31:0] in_alu_result_i;
    logic [31:0] in_store_data_i;
    logic [4:0]  in_rd_i;
    logic        in_rf_we_i;
    logic        commit_ready_i;
    logic [4:0]  rf_raddr_i;
    logic [31:0] rf_rdata_o;
    logic        wb_valid_o;
    logic [31:0] wb_pc_o;
    logic        wb_we_o;
    logic [4:0]  wb_waddr_o;
    logic [31:0] wb_wdata_o;

    issued_t     inflight[$];                          // Accepted, not yet retired
    logic [7:0]  ref_bytes [RAM_BYTES];                // Byte view of the data RAM
    logic [31:0] ref_regs [32];
    logic        exp_known;                            // Queue had a head for this commit
    logic [31:0] exp_pc;
    logic        exp_we;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    string       exp_test;
    logic [2:0]  cur_test;
    logic        ready_random;                         // commit_ready_i from $urandom
    logic [31:0] next_pc;
    int          cycles        = 0;
    int          issued        = 0;
    int          commits       = 0;
    int          last_wait     = 0;
    int          commit_errors = 0;
    int          check_errors  = 0;

    tb_clk_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(10)) u_clk_gen (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    mem_wb_top #(.RAM_WORDS(RAM_WORDS)) u_mem_wb_top (.*);

    function automatic string test_name(logic [2:0] id);
        case (id)
            3'd1:    return "reset_state";
            3'd2:    return "alu_commit";
            3'd3:    return "load_store";
            3'd4:    return "stall_hold";
            3'd5:    return "burst";
            default: return "random_mix";
        endcase
    endfunction

    // Reference behavior, applied in commit order which is also memory order
    task automatic predict(input issued_t t, output logic [31:0] res);
        int          a;
        int          n;
        int          base;
        logic [31:0] word;
        a = t.alu % RAM_BYTES;                         // Address wraps at the RAM size
        case (t.op)
            MEM_SB, MEM_LB, MEM_LBU: n = 1;
            MEM_SH, MEM_LH, MEM_LHU: n = 2;
            default:                 n = 4;
        endcase
        base = a - (a % n);                            // Low bits ignored for h and w
        word = '0;
        for (int i = 0; i < n; i++) begin
            if (t.op inside {MEM_SB, MEM_SH, MEM_SW}) ref_bytes[base + i] = t.sdata[8*i +: 8];
            word[8*i +: 8] = ref_bytes[base + i];      // Little endian lanes
        end
        case (t.op)
            MEM_LB:                   res = {{24{word[7]}}, word[7:0]};
            MEM_LH:                   res = {{16{word[15]}}, word[15:0]};
            MEM_LBU, MEM_LHU, MEM_LW: res = word;      // Upper bytes already zero
            default:                  res = t.alu;
        endcase
        if (t.rf_we && t.rd != 5'd0) ref_regs[t.rd] = res;
    endtask

    // Pre-edge values are stable at the falling edge
    always @(negedge clk) begin : track
        issued_t     head;
        logic [31:0] res;
        if (!reset_i) begin
            if (in_valid_i && in_allowin_o) begin
                inflight.push_back('{pc: in_pc_i, op: in_op_i, alu: in_alu_result_i,
                                     sdata: in_store_data_i, rd: in_rd_i, rf_we: in_rf_we_i,
                                     test_id: cur_test, accept_edge: cycles + 1});
                issued++;
            end
            if (wb_valid_o && commit_ready_i) begin
                exp_known = (inflight.size() != 0);
                if (exp_known) begin
                    head = inflight.pop_front();
                    predict(head, res);
                    exp_pc   = head.pc;
                    exp_we   = head.rf_we && head.rd != 5'd0;
                    exp_rd   = head.rd;
                    exp_data = res;
                    exp_test = test_name(head.test_id);
                    commits++;
                    if (head.test_id == 3'd5) begin
                        assert (cycles + 1 - head.accept_edge == 2) else begin
                            check_errors++;
                            $display("[FAIL] burst latency: expected 2 actual %0d",
                                     cycles + 1 - head.accept_edge);
                        end
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset_i)
            (wb_valid_o && commit_ready_i) |-> exp_known)
        else begin
            commit_errors++;
            $display("Commit at pc %h with no instruction outstanding", $sampled(wb_pc_o));
        end

    assert property (@(posedge clk) disable iff (reset_i)
            (wb_valid_o && commit_ready_i && exp_known) |->
            ({wb_pc_o, wb_we_o, wb_waddr_o, wb_wdata_o} == {exp_pc, exp_we, exp_rd, exp_data}))
        else begin
            commit_errors++;
            $display("[FAIL] %s: expected pc %h we %b rd %0d data %h, actual pc %h we %b rd %0d data %h",
                     exp_test, exp_pc, exp_we, exp_rd, exp_data, $sampled(wb_pc_o),
                     $sampled(wb_we_o), $sampled(wb_waddr_o), $sampled(wb_wdata_o));
        end

    // Stalled trace stays put
    assert property (@(posedge clk) disable iff (reset_i)
            (wb_valid_o && !commit_ready_i) |=>
            (wb_valid_o && $stable({wb_pc_o, wb_we_o, wb_waddr_o, wb_wdata_o})))
        else begin
            check_errors++;
            $display("Commit trace changed during a stall, pc now %h", wb_pc_o);
        end

    always @(posedge clk) begin
        if (ready_random) commit_ready_i <= ($urandom_range(3) != 0);   // High 3 of 4
    end

    task automatic drive_inst(input mem_op_e op, input logic [31:0] alu,
                              input logic [31:0] sdata, input logic [4:0] rd,
                              input logic rf_we);
        in_valid_i      <= 1'b1;
        in_pc_i         <= next_pc;
        in_inst_i       <= {next_pc[27:0], op};        // Word content unused
        in_op_i         <= op;
        in_alu_result_i <= alu;
        in_store_data_i <= sdata;
        in_rd_i         <= rd;
        in_rf_we_i      <= rf_we;
        next_pc = next_pc + 32'd4;
    endtask

    // Holds the instruction until in_allowin_o takes it, counts edges waited
    task automatic wait_accept();
        logic ok;
        last_wait = 0;
        ok        = 1'b0;
        while (!ok) begin
            @(negedge clk);
            ok = in_allowin_o;
            @(posedge clk);
            if (!ok) last_wait++;
        end
        in_valid_i <= 1'b0;                            // A following issue overrides
    endtask

    task automatic issue(input mem_op_e op, input logic [31:0] alu,
                         input logic [31:0] sdata, input logic [4:0] rd,
                         input logic rf_we);
        drive_inst(op, alu, sdata, rd, rf_we);
        wait_accept();
    endtask

    task automatic drain();
        do @(negedge clk); while (inflight.size() != 0 || wb_valid_o);
        @(posedge clk);
    endtask

    task automatic check_reg(input logic [4:0] a);
        rf_raddr_i <= a;
        @(negedge clk);
        assert (rf_rdata_o === ref_regs[a]) else begin
            check_errors++;
            $display("[FAIL] %s x%0d: expected %h actual %h",
                     test_name(cur_test), a, ref_regs[a], rf_rdata_o);
        end
        @(posedge clk);
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < 32; i++) check_reg(5'(i));
    endtask

    initial begin : stimulus
        int r;
        int clear_cycles;
        int held;
        void'($urandom(SEED));
        in_valid_i      = 1'b0;
        in_pc_i         = '0;
        in_inst_i       = '0;
        in_op_i         = MEM_NONE;
        in_alu_result_i = '0;
        in_store_data_i = '0;
        in_rd_i         = '0;
        in_rf_we_i      = 1'b0;
        commit_ready_i  = 1'b1;
        rf_raddr_i      = '0;
        ready_random    = 1'b0;
        exp_known       = 1'b0;
        next_pc         = 32'h0000_1000;
        for (int i = 0; i < RAM_BYTES; i++) ref_bytes[i] = 8'h00;
        for (int i = 0; i < 32; i++) ref_regs[i] = 32'h0;

        cur_test     = 3'd1;
        clear_cycles = 0;
        do begin
            @(negedge clk);
            if (!reset_i && in_allowin_o !== 1'b1) clear_cycles++;
        end while (reset_i || in_allowin_o !== 1'b1);
        assert (clear_cycles == RAM_WORDS) else begin
            check_errors++;
            $display("[FAIL] reset_state clear: expected %0d actual %0d", RAM_WORDS, clear_cycles);
        end
        assert (wb_valid_o === 1'b0 && wb_we_o === 1'b0) else begin
            check_errors++;
            $display("Writeback outputs not idle after reset and RAM clear");
        end
        @(posedge clk);
        check_all_regs();

        cur_test = 3'd2;
        for (int i = 1; i < 9; i++) issue(MEM_NONE, 32'h1111_0000 * i + i, $urandom, 5'(i), 1'b1);
        issue(MEM_NONE, 32'hDEAD_0000, 32'h0, 5'd0, 1'b1);   // x0 stays zero
        issue(MEM_NONE, 32'hBAD0_0005, 32'h0, 5'd5, 1'b0);   // Write flag clear
        drain();
        check_all_regs();

        cur_test = 3'd3;
        issue(MEM_SW, 32'h40, 32'h80F1_7F22, 5'd0, 1'b0);
        issue(MEM_SB, 32'h45, 32'h1234_56A5, 5'd0, 1'b0);    // Upper bits are junk
        issue(MEM_SB, 32'h47, 32'hFFFF_FF7E, 5'd0, 1'b0);
        issue(MEM_SH, 32'h48, 32'hAAAA_9C3B, 5'd0, 1'b0);
        issue(MEM_SH, 32'h4B, 32'h5555_1284, 5'd0, 1'b0);    // Lands at 0x4A
        issue(MEM_SW, 32'h1000_004E, 32'hC001_D00D, 5'd0, 1'b0);   // Wraps, lands at 0x4C
        for (int a = 'h40; a < 'h50; a++) begin
            for (int k = 1; k <= 5; k++) issue(mem_op_e'(k), a, 32'h0, 5'((a + k) % 31 + 1), 1'b1);
        end
        drain();

        cur_test = 3'd4;
        commit_ready_i <= 1'b0;
        issue(MEM_NONE, 32'h4444_0001, 32'h0, 5'd10, 1'b1);
        issue(MEM_LW, 32'h40, 32'h0, 5'd11, 1'b1);
        drive_inst(MEM_NONE, 32'h4444_0003, 32'h0, 5'd12, 1'b1);
        held = commits;
        repeat (6) begin
            @(negedge clk);
            assert (!in_allowin_o && wb_valid_o) else begin
                check_errors++;
                $display("Pipeline did not hold its contents under back-pressure");
            end
            @(posedge clk);
        end
        commit_ready_i <= 1'b1;
        wait_accept();
        drain();
        assert (commits - held == 3) else begin
            check_errors++;
            $display("[FAIL] stall_hold commits: expected 3 actual %0d", commits - held);
        end

        cur_test = 3'd5;
        for (int i = 0; i < 6; i++) begin
            issue(MEM_NONE, 32'h5555_0000 + i, 32'h0, 5'(20 + i), 1'b1);
            assert (last_wait == 0) else begin
                check_errors++;
                $display("[FAIL] burst accept wait: expected 0 actual %0d", last_wait);
            end
        end
        drain();

        cur_test     = 3'd6;
        ready_random <= 1'b1;
        repeat (60) begin
            r = $urandom_range(11);
            issue(r > 8 ? MEM_NONE : mem_op_e'(r), $urandom & 32'hF000_001F, $urandom,
                  5'($urandom), $urandom_range(3) != 0);
            repeat ($urandom_range(3)) @(posedge clk);   // Random gap
        end
        ready_random = 1'b0;
        commit_ready_i <= 1'b1;
        drain();
        check_all_regs();

        assert (inflight.size() == 0 && commits == issued) else begin
            check_errors++;
            $display("Instructions lost: %0d issued, %0d committed", issued, commits);
        end
        $display("Errors: %0d commit, %0d other (%0d issued, %0d committed)",
                 commit_errors, check_errors, issued, commits);
        if (commit_errors + check_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Limit grows with each accepted instruction
    initial begin : watchdog
        while (cycles <= RAM_WORDS + 20 * issued + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d of %0d committed, errors: %0d commit, %0d other",
                 cycles, commits, issued, commit_errors, check_errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: tb_clk_gen.sv
//********************
// Testbench clock and reset,
// 8 ns period, 10-cycle reset
//********************
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;   // First rising edge at half a period
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;                               // Drops on the last reset edge
    end

endmodule

// File: mem_wb_top.sv
//********************
// Back end top: ex/mem and mem/wb
// registers, MEM, WB, register file
//********************
`timescale 1ns/1ps

module mem_wb_top #(
    parameter int RAM_WORDS = 256
) (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                in_valid_i,
    output logic                                in_allowin_o,
    input  logic [cpu_isa_pkg::XLEN-1:0]        in_pc_i,
    input  logic [cpu_isa_pkg::XLEN-1:0]        in_inst_i,
    input  cpu_isa_pkg::mem_op_e                in_op_i,
    input  logic [cpu_isa_pkg::XLEN-1:0]        in_alu_result_i,
    input  logic [cpu_isa_pkg::XLEN-1:0]        in_store_data_i,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  in_rd_i,
    input  logic                                in_rf_we_i,
    input  logic                                commit_ready_i,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rf_raddr_i,
    output logic [cpu_isa_pkg::XLEN-1:0]        rf_rdata_o,
    output logic                                wb_valid_o,
    output logic [cpu_isa_pkg::XLEN-1:0]        wb_pc_o,
    output logic                                wb_we_o,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  wb_waddr_o,
    output logic [cpu_isa_pkg::XLEN-1:0]        wb_wdata_o
);

    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    stage_if #(.PAYLOAD_T(exe_mem_t)) ex_mem_in_if ();   // Top ports in
    stage_if #(.PAYLOAD_T(exe_mem_t)) ex_mem_if ();      // ex/mem reg to MEM
    stage_if #(.PAYLOAD_T(mem_wb_t))  mem_wb_if ();      // MEM to mem/wb reg
    stage_if #(.PAYLOAD_T(mem_wb_t))  wb_if ();          // mem/wb reg to WB

    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    assign ex_mem_in_if.valid   = in_valid_i;
    assign in_allowin_o         = ex_mem_in_if.allowin;
    assign ex_mem_in_if.pc_inst = '{pc: in_pc_i, inst: in_inst_i};
    assign ex_mem_in_if.payload = '{alu_result: in_alu_result_i,
                                    store_data: in_store_data_i,
                                    op:         in_op_i,
                                    rd:         in_rd_i,
                                    rf_we:      in_rf_we_i};

    stage_reg #(.PAYLOAD_T(exe_mem_t)) u_ex_mem_reg (
        .clk (clk), .reset_i (reset_i), .up (ex_mem_in_if.dst), .down (ex_mem_if.src)
    );

    mem_stage #(.RAM_WORDS(RAM_WORDS)) u_mem_stage (
        .clk (clk), .reset_i (reset_i), .in (ex_mem_if.dst), .out (mem_wb_if.src)
    );

    stage_reg #(.PAYLOAD_T(mem_wb_t)) u_mem_wb_reg (
        .clk (clk), .reset_i (reset_i), .up (mem_wb_if.dst), .down (wb_if.src)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .reset_i        (reset_i),
        .in             (wb_if.dst),
        .commit_ready_i (commit_ready_i),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .wb_valid_o     (wb_valid_o),
        .wb_pc_o        (wb_pc_o),
        .wb_we_o        (wb_we_o),
        .wb_waddr_o     (wb_waddr_o),
        .wb_wdata_o     (wb_wdata_o)
    );

    regfile u_regfile (
        .clk     (clk),
        .reset_i (reset_i),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

endmodule

// File: regfile.sv
//********************
// 32 x 32 register file, x0 reads 0
// one write, one async read port
//********************
`timescale 1ns/1ps

module regfile (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                we_i,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  waddr_i,
    input  logic [cpu_isa_pkg::XLEN-1:0]        wdata_i,
    input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  raddr_i,
    output logic [cpu_isa_pkg::XLEN-1:0]        rdata_o
);

    import cpu_isa_pkg::*;

    localparam int NREGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [1:NREGS-1];        // No storage behind x0

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // No bypass, a same-cycle write shows up next cycle
    assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

// File: wb_stage.sv
//********************
// Writeback: register-file write
// and commit trace
//********************
`timescale 1ns/1ps

module wb_stage (
    input  logic                                clk,
    input  logic                                reset_i,
    stage_if.dst                                in,            // From the mem/wb register
    input  logic                                commit_ready_i,
    output logic                                rf_we_o,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rf_waddr_o,
    output logic [cpu_isa_pkg::XLEN-1:0]        rf_wdata_o,
    output logic                                wb_valid_o,
    output logic [cpu_isa_pkg::XLEN-1:0]        wb_pc_o,
    output logic                                wb_we_o,
    output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  wb_waddr_o,
    output logic [cpu_isa_pkg::XLEN-1:0]        wb_wdata_o
);

    import cpu_pipe_pkg::*;

    mem_wb_t     wb;
    pc_inst_t    pi;
    logic        finish;                      // Retires at the next edge
    logic        writes_rf;                   // Architecturally visible write

    assign wb        = in.payload;
    assign pi        = in.pc_inst;
    assign finish    = in.valid & commit_ready_i;
    assign writes_rf = in.valid & wb.rf_we & (wb.rd != '0);   // x0 never written

    assign in.allowin = ~in.valid | finish;

    assign rf_we_o    = writes_rf & finish;
    assign rf_waddr_o = wb.rd;
    assign rf_wdata_o = wb.result;

    // Trace follows the held register, so it is steady during a stall
    assign wb_valid_o = in.valid;
    assign wb_pc_o    = pi.pc;
    assign wb_we_o    = writes_rf;
    assign wb_waddr_o = wb.rd;
    assign wb_wdata_o = wb.result;

endmodule

// File: mem_stage.sv
//********************
// Memory stage: address split, store
// lane steering, load extraction
//********************
`timescale 1ns/1ps

module mem_stage #(
    parameter int RAM_WORDS = 256
) (
    input  logic clk,
    input  logic reset_i,
    stage_if.dst in,                          // exe_mem_t from the ex/mem register
    stage_if.src out                          // mem_wb_t toward the mem/wb register
);

    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    localparam int AW = $clog2(RAM_WORDS);

    exe_mem_t        ex;
    mem_wb_t         res;
    mem_size_e       size;
    logic [1:0]      offset;                  // Byte within the word
    logic [AW-1:0]   word_idx;                // Address modulo depth
    logic [XLEN-1:0] st_wdata;
    logic [3:0]      st_be;
    logic [XLEN-1:0] ram_rdata;
    logic            ram_busy;
    logic            ram_we;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] ld_value;

    assign ex       = in.payload;
    assign size     = mem_size(ex.op);
    assign offset   = ex.alu_result[1:0];
    assign word_idx = ex.alu_result[AW+1:2];

    // Replicate the source across lanes, enables pick the lane
    always_comb begin
        case (size)
            SIZE_B: begin
                st_wdata = {4{ex.store_data[7:0]}};
                st_be    = 4'b0001 << offset;
            end
            SIZE_H: begin
                st_wdata = {2{ex.store_data[15:0]}};
                st_be    = offset[1] ? 4'b1100 : 4'b0011;   // Bit 0 ignored
            end
            default: begin
                st_wdata = ex.store_data;
                st_be    = 4'b1111;
            end
        endcase
    end

    assign ld_byte = ram_rdata[8*offset +: 8];
    assign ld_half = offset[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        case (size)
            SIZE_B:  ld_value = load_unsigned(ex.op) ? {24'd0, ld_byte}
                                                     : {{24{ld_byte[7]}}, ld_byte};
            SIZE_H:  ld_value = load_unsigned(ex.op) ? {16'd0, ld_half}
                                                     : {{16{ld_half[15]}}, ld_half};
            default: ld_value = ram_rdata;
        endcase
    end

    // Single cycle stage, stalls only while the RAM clears
    assign in.allowin  = ~ram_busy & (~in.valid | out.allowin);
    assign out.valid   = in.valid & ~ram_busy;
    assign ram_we      = out.valid & out.allowin & is_store(ex.op);   // Transfer edge only

    assign res.result  = is_load(ex.op) ? ld_value : ex.alu_result;
    assign res.rd      = ex.rd;
    assign res.rf_we   = ex.rf_we;
    assign out.payload = res;
    assign out.pc_inst = in.pc_inst;

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clk     (clk),
        .reset_i (reset_i),
        .addr_i  (word_idx),
        .wdata_i (st_wdata),
        .be_i    (st_be),
        .we_i    (ram_we),
        .rdata_o (ram_rdata),
        .busy_o  (ram_busy)
    );

endmodule

// File: data_ram.sv
//********************
// Word data RAM, byte-enable write,
// async read, clear after reset
//********************
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_WORDS = 256             // Power of two
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [$clog2(RAM_WORDS)-1:0]  addr_i,     // Word index
    input  logic [cpu_isa_pkg::XLEN-1:0]  wdata_i,
    input  logic [3:0]                    be_i,       // One bit per byte lane
    input  logic                          we_i,
    output logic [cpu_isa_pkg::XLEN-1:0]  rdata_o,
    output logic                          busy_o      // Clear in progress
);

    import cpu_isa_pkg::*;

    localparam int AW = $clog2(RAM_WORDS);

    logic [XLEN-1:0] mem [RAM_WORDS];
    logic [AW-1:0]   clr_cnt_q;
    logic            busy_q;

    // Clear sequencer, one word per cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q    <= 1'b1;
            clr_cnt_q <= '0;
        end else if (busy_q) begin
            clr_cnt_q <= clr_cnt_q + 1'b1;
            if (clr_cnt_q == AW'(RAM_WORDS - 1)) begin
                busy_q <= 1'b0;               // Last word done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy_q) begin
            mem[clr_cnt_q] <= '0;
        end else if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    assign rdata_o = mem[addr_i];             // Combinational read
    assign busy_o  = busy_q;

endmodule

// File: stage_reg.sv
//********************
// Pipeline register for one stage
// valid bit, pc/inst and payload
//********************
`timescale 1ns/1ps

module stage_reg #(
    parameter type PAYLOAD_T = logic
) (
    input  logic clk,
    input  logic reset_i,
    stage_if.dst up,                          // From the producing stage
    stage_if.src down                         // Into the consuming stage
);

    import cpu_pipe_pkg::*;

    logic     valid_q;
    pc_inst_t pc_inst_q;
    PAYLOAD_T payload_q;
    logic     take;

    // Consumer folds our emptiness (down.valid) into its allowin
    assign up.allowin = down.allowin;
    assign take       = up.valid & up.allowin;   // Transfer in this edge

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (up.allowin) begin
            valid_q <= up.valid;              // Empties when nothing follows
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_inst_q <= '0;
            payload_q <= '0;
        end else if (take) begin
            pc_inst_q <= up.pc_inst;
            payload_q <= up.payload;
        end
    end

    assign down.valid   = valid_q;
    assign down.pc_inst = pc_inst_q;
    assign down.payload = payload_q;

endmodule

// File: stage_if.sv
//********************
// Inter-stage bus: valid/allowin,
// pc/instruction and payload
//********************
`timescale 1ns/1ps

interface stage_if #(
    parameter type PAYLOAD_T = logic          // Stage specific payload struct
);

    import cpu_pipe_pkg::*;

    logic     valid;                          // Upstream holds an instruction
    logic     allowin;                        // Downstream can take it
    pc_inst_t pc_inst;
    PAYLOAD_T payload;

    // Producer side
    modport src (
        output valid,
        output pc_inst,
        output payload,
        input  allowin
    );

    // Consumer side
    modport dst (
        input  valid,
        input  pc_inst,
        input  payload,
        output allowin
    );

endinterface

// File: cpu_pipe_pkg.sv
//********************
// Stage payload structs for the
// exe/mem and mem/wb buses
//********************
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    // Travels with every instruction down the pipe, 64 bits
    typedef struct packed {
        logic [XLEN-1:0] pc;                  // Instruction address
        logic [XLEN-1:0] inst;                // Raw instruction word
    } pc_inst_t;

    // Execute to memory, 74 bits
    typedef struct packed {
        logic [XLEN-1:0]       alu_result;    // Also the effective address
        logic [XLEN-1:0]       store_data;    // Unaligned source value
        mem_op_e               op;            // Load/store kind
        logic [REG_ADDR_W-1:0] rd;            // Destination register
        logic                  rf_we;         // Register write request
    } exe_mem_t;

    // Memory to writeback, 38 bits
    typedef struct packed {
        logic [XLEN-1:0]       result;        // Load data or ALU result
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_we;
    } mem_wb_t;

endpackage

// File: cpu_isa_pkg.sv
//********************
// Integer ISA widths, memory op codes
// and load/store size helpers
//********************
package cpu_isa_pkg;

    localparam int XLEN       = 32;           // Data and address width
    localparam int REG_ADDR_W = 5;            // 32 architectural registers

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,                      // No memory access
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,                        // Byte
        SIZE_H = 2'd1,                        // Halfword
        SIZE_W = 2'd2                         // Word
    } mem_size_e;

    function automatic logic is_load(mem_op_e op);
        return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

    function automatic mem_size_e mem_size(mem_op_e op);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: return SIZE_B;
            MEM_LH, MEM_LHU, MEM_SH: return SIZE_H;
            default:                 return SIZE_W;   // LW, SW and no-op
        endcase
    endfunction

    // Zero extension only for the U variants
    function automatic logic load_unsigned(mem_op_e op);
        return op inside {MEM_LBU, MEM_LHU};
    endfunction

endpackage
